// File: dma_cfg_pkg.sv
package dma_cfg_pkg;

    import dma_noc_pkg::*;

    typedef enum logic {
        HERMES_OP_SEND,
        HERMES_OP_RECEIVE
    } hermes_op_t;

    // One software command, sizes count words
    typedef struct packed {
        logic        start;
        hermes_op_t  operation;
        logic [31:0] size;
        logic [31:0] size_2;
        addr_t       address;
        addr_t       address_2;
    } dma_cfg_t;

    // Status seen by software
    typedef struct packed {
        logic  send_active;
        logic  receive_active;
        logic  receive_available;
        flit_t flits_available;
    } dma_status_t;

endpackage

// File: dma_noc_pkg.sv
package dma_noc_pkg;

    ////////////////////
    // Widths and timing
    ////////////////////

    localparam int FLIT_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int WORD_BYTES = 4;

    // Reload value of the arbiter slice timer
    localparam logic [3:0] SLICE_CYCLES = 4'd15;

    typedef logic [FLIT_W-1:0] flit_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // One memory access, we is a byte mask
    typedef struct packed {
        logic [3:0] we;
        addr_t      addr;
        flit_t      wdata;
    } mem_req_t;

    // Hermes input port as seen by the receiver
    typedef struct packed {
        logic  rx;
        flit_t data;
    } noc_in_t;

    typedef enum logic {
        ARBIT_SEND,
        ARBIT_RECEIVE
    } arbit_t;

endpackage

// File: hermes_dma.f
dma_noc_pkg.sv
dma_cfg_pkg.sv
noc_receive.sv
noc_send.sv
mem_arbiter.sv
hermes_dma.sv
hermes_dma_tb.sv

// File: hermes_dma.sv
module hermes_dma
    import dma_noc_pkg::*;
    import dma_cfg_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,

    input  noc_in_t     noc_i,
    output logic        noc_credit_o,

    output logic        noc_tx_o,
    input  logic        noc_ack_i,
    output flit_t       noc_data_o,

    output mem_req_t    mem_req_o,
    input  flit_t       mem_rdata_i,

    input  dma_cfg_t    cfg_i,
    output dma_status_t status_o
);

    logic     send_pending;
    logic     receive_pending;
    logic     send_grant;
    logic     receive_grant;
    mem_req_t send_req;
    mem_req_t receive_req;

    logic     send_active;
    logic     receive_active;
    logic     receive_available;
    flit_t    flits_available;

    assign status_o = {send_active, receive_active, receive_available, flits_available};

    noc_receive u_receive (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .noc_i               (noc_i),
        .noc_credit_o        (noc_credit_o),
        .cfg_i               (cfg_i),
        .grant_i             (receive_grant),
        .pending_o           (receive_pending),
        .mem_req_o           (receive_req),
        .receive_active_o    (receive_active),
        .receive_available_o (receive_available),
        .flits_available_o   (flits_available)
    );

    noc_send u_send (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .cfg_i         (cfg_i),
        .grant_i       (send_grant),
        .noc_ack_i     (noc_ack_i),
        .mem_rdata_i   (mem_rdata_i),
        .noc_tx_o      (noc_tx_o),
        .noc_data_o    (noc_data_o),
        .pending_o     (send_pending),
        .mem_req_o     (send_req),
        .send_active_o (send_active)
    );

    mem_arbiter u_arbiter (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .send_pending_i    (send_pending),
        .receive_pending_i (receive_pending),
        .send_req_i        (send_req),
        .receive_req_i     (receive_req),
        .send_grant_o      (send_grant),
        .receive_grant_o   (receive_grant),
        .mem_req_o         (mem_req_o)
    );

endmodule

// File: hermes_dma_tb.sv
module hermes_dma_tb
    import dma_noc_pkg::*;
    import dma_cfg_pkg::*;
();

    logic        clk_i;
    logic        rst_ni;
    noc_in_t     noc_i;
    logic        noc_credit_o;
    logic        noc_tx_o;
    logic        noc_ack_i;
    flit_t       noc_data_o;
    mem_req_t    mem_req_o;
    flit_t       mem_rdata_i;
    dma_cfg_t    cfg_i;
    dma_status_t status_o;

    flit_t       mem [0:4095];
    flit_t       rdata_next;
    flit_t       rx_flits[$];
    flit_t       tx_got[$];
    flit_t       tx_expect[$];
    int          rx_idx;
    int          cycle_count;
    int          cycle_limit;
    logic [31:0] rand_state;
    dma_cfg_t    cmd_next;
    logic        cmd_valid;

    hermes_dma dut0 (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .noc_i        (noc_i),
        .noc_credit_o (noc_credit_o),
        .noc_tx_o     (noc_tx_o),
        .noc_ack_i    (noc_ack_i),
        .noc_data_o   (noc_data_o),
        .mem_req_o    (mem_req_o),
        .mem_rdata_i  (mem_rdata_i),
        .cfg_i        (cfg_i),
        .status_o     (status_o)
    );

    always #2 clk_i = ~clk_i;

    function automatic flit_t next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return {rand_state[15:0], rand_state[31:16]};
    endfunction

    function automatic logic [11:0] mem_index(addr_t a);
        return a[13:2];
    endfunction

    function automatic dma_status_t make_status(logic sa, logic ra, logic av, flit_t flits);
        dma_status_t s;
        s.send_active       = sa;
        s.receive_active    = ra;
        s.receive_available = av;
        s.flits_available   = flits;
        return s;
    endfunction

    function automatic dma_cfg_t make_cmd(hermes_op_t op, logic [31:0] size,
                                          logic [31:0] size_2, addr_t a, addr_t a_2);
        dma_cfg_t c;
        c.start     = 1'b1;
        c.operation = op;
        c.size      = size;
        c.size_2    = size_2;
        c.address   = a;
        c.address_2 = a_2;
        return c;
    endfunction

    ////////////////////
    // Checks
    ////////////////////

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flit(string name, flit_t got, flit_t exp);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_status(dma_status_t got, dma_status_t exp);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] status_o: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_word(addr_t a, flit_t exp);
        flit_t got;
        got = mem[mem_index(a)];
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] mem[%h]: got %h expected %h", a, got, exp));
        end
    endtask

    ////////////////////
    // Cycle driver and NoC/memory models
    ////////////////////

    task automatic step();
        logic [11:0] idx;
        @(negedge clk_i);
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            report_failure("Timeout: the DUT did not finish within the cycle limit");
        end
        rst_ni      = (cycle_count > 16);
        mem_rdata_i = rdata_next;
        noc_ack_i   = (next_random() % 4) != 0;
        noc_i.rx    = (rx_idx < rx_flits.size()) && ((next_random() % 4) != 0);
        noc_i.data  = (rx_idx < rx_flits.size()) ? rx_flits[rx_idx] : '0;
        cfg_i       = cmd_valid ? cmd_next : '0;
        cmd_valid   = 1'b0;
        #1;
        // Outputs are settled here until the next rising edge
        if (noc_i.rx && noc_credit_o) begin
            rx_idx++;
        end
        if (noc_tx_o && noc_ack_i) begin
            tx_got.push_back(noc_data_o);
        end
        idx        = mem_index(mem_req_o.addr);
        rdata_next = mem[idx];
        for (int b = 0; b < 4; b++) begin
            if (mem_req_o.we[b]) begin
                mem[idx][8*b +: 8] = mem_req_o.wdata[8*b +: 8];
            end
        end
    endtask

    // Start pulse, then one cycle for the state to move
    task automatic start_command(dma_cfg_t c);
        cmd_next  = c;
        cmd_valid = 1'b1;
        step();
        step();
    endtask

    task automatic wait_available();
        while (!status_o.receive_available) begin
            step();
        end
    endtask

    task automatic wait_receive_done();
        while (status_o.receive_active) begin
            step();
        end
    endtask

    // Last flit delivered, send_active must be low one cycle later
    task automatic wait_send_done();
        while (tx_got.size() < tx_expect.size()) begin
            step();
        end
        step();
        check_bit("send_active", status_o.send_active, 1'b0);
    endtask

    // Header, size flit, then random payload
    task automatic load_packet(int n);
        rx_flits.delete();
        rx_idx = 0;
        rx_flits.push_back(32'h0000_0100);
        rx_flits.push_back(flit_t'(n));
        for (int i = 0; i < n; i++) begin
            rx_flits.push_back(next_random());
        end
    endtask

    task automatic check_rx_words(addr_t a, int first, int count);
        for (int i = 0; i < count; i++) begin
            check_word(a + addr_t'(4 * i), rx_flits[2 + first + i]);
        end
    endtask

    task automatic run_receive(int n, int k, addr_t a, addr_t a_2);
        load_packet(n);
        wait_available();
        check_status(status_o, make_status(1'b0, 1'b0, 1'b1, flit_t'(n)));
        start_command(make_cmd(HERMES_OP_RECEIVE, k, 0, a, '0));
        wait_receive_done();
        if (k < n) begin
            check_status(status_o, make_status(1'b0, 1'b0, 1'b1, flit_t'(n - k)));
            start_command(make_cmd(HERMES_OP_RECEIVE, n - k, 0, a_2, '0));
            wait_receive_done();
            check_rx_words(a_2, k, n - k);
        end
        check_status(status_o, make_status(1'b0, 1'b0, 1'b0, '0));
        check_rx_words(a, 0, k);
    endtask

    task automatic prepare_send(int s1, int s2, addr_t b1, addr_t b2);
        flit_t w;
        tx_expect.delete();
        tx_got.delete();
        for (int i = 0; i < s1 + s2; i++) begin
            w = next_random();
            if (i < s1) begin
                mem[mem_index(b1 + addr_t'(4 * i))] = w;
            end else begin
                mem[mem_index(b2 + addr_t'(4 * (i - s1)))] = w;
            end
            tx_expect.push_back(w);
        end
    endtask

    // Delivered order is buffer 1 then buffer 2, buffers untouched
    task automatic check_send(int s1, int s2, addr_t b1, addr_t b2);
        if (tx_got.size() != tx_expect.size()) begin
            report_failure($sformatf("Sender delivered %0d flits instead of %0d",
                                     tx_got.size(), tx_expect.size()));
        end
        for (int i = 0; i < s1 + s2; i++) begin
            check_flit("noc_data_o", tx_got[i], tx_expect[i]);
            if (i < s1) begin
                check_word(b1 + addr_t'(4 * i), tx_expect[i]);
            end else begin
                check_word(b2 + addr_t'(4 * (i - s1)), tx_expect[i]);
            end
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        int    n2;
        int    n3;
        int    k3;
        int    n5;
        int    s1_4;
        int    s2_4;
        int    s1_5;
        int    s2_5;
        addr_t b1;
        addr_t b2;
        addr_t a;
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        noc_i       = '0;
        noc_ack_i   = 1'b0;
        mem_rdata_i = '0;
        cfg_i       = '0;
        cmd_next    = '0;
        cmd_valid   = 1'b0;
        rdata_next  = '0;
        rx_idx      = 0;
        cycle_count = 0;
        rand_state  = 32'd22;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = {4'hD, i[11:0], 4'h3, ~i[11:0]};
        end
        n2   = 1 + int'(next_random() % 16);
        n3   = 2 + int'(next_random() % 15);
        k3   = 1 + int'(next_random() % 32'(n3 - 1));
        n5   = 1 + int'(next_random() % 16);
        s1_4 = int'(next_random() % 13);
        s2_4 = int'(next_random() % 13);
        s1_5 = int'(next_random() % 13);
        s2_5 = 1 + int'(next_random() % 12);
        if (s1_4 + s2_4 == 0) begin
            s1_4 = 1;
        end
        cycle_limit = 64 * (n2 + n3 + n5 + 6 + s1_4 + s2_4 + s1_5 + s2_5) + 2000;

        // 1: idle after reset
        repeat (17) step();
        check_bit("noc_tx_o", noc_tx_o, 1'b0);
        check_bit("noc_credit_o", noc_credit_o, 1'b1);
        check_bit("mem_req_o.we", |mem_req_o.we, 1'b0);
        check_status(status_o, make_status(1'b0, 1'b0, 1'b0, '0));

        // 2: full receive, 3: split receive
        a = 32'h3000 + addr_t'(4 * (next_random() % 64));
        run_receive(n2, n2, a, '0);
        a = 32'h3000 + addr_t'(4 * (next_random() % 64));
        run_receive(n3, k3, a, 32'h3400 + addr_t'(4 * (next_random() % 64)));

        // 4: gather send with ack drops
        b1 = 32'h1000 + addr_t'(4 * (next_random() % 64));
        b2 = 32'h2000 + addr_t'(4 * (next_random() % 64));
        prepare_send(s1_4, s2_4, b1, b2);
        start_command(make_cmd(HERMES_OP_SEND, s1_4, s2_4, b1, b2));
        wait_send_done();
        check_send(s1_4, s2_4, b1, b2);

        // 5: send and receive overlap on the memory port
        b1 = 32'h1000 + addr_t'(4 * (next_random() % 64));
        b2 = 32'h2000 + addr_t'(4 * (next_random() % 64));
        a  = 32'h3000 + addr_t'(4 * (next_random() % 64));
        load_packet(n5);
        prepare_send(s1_5, s2_5, b1, b2);
        start_command(make_cmd(HERMES_OP_SEND, s1_5, s2_5, b1, b2));
        wait_available();
        check_flit("flits_available", status_o.flits_available, flit_t'(n5));
        start_command(make_cmd(HERMES_OP_RECEIVE, n5, 0, a, '0));
        wait_send_done();
        wait_receive_done();
        check_send(s1_5, s2_5, b1, b2);
        check_rx_words(a, 0, n5);
        check_status(status_o, make_status(1'b0, 1'b0, 1'b0, '0));

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: mem_arbiter.sv
module mem_arbiter
    import dma_noc_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     send_pending_i,
    input  logic     receive_pending_i,
    input  mem_req_t send_req_i,
    input  mem_req_t receive_req_i,
    output logic     send_grant_o,
    output logic     receive_grant_o,
    output mem_req_t mem_req_o
);

    arbit_t     owner_q;
    logic [3:0] timer_q;
    logic       owner_pending;
    logic       other_pending;
    logic       switch_owner;

    assign owner_pending = (owner_q == ARBIT_SEND) ? send_pending_i : receive_pending_i;
    assign other_pending = (owner_q == ARBIT_SEND) ? receive_pending_i : send_pending_i;

    // Hand over on slice expiry or when the owner goes quiet
    assign switch_owner = other_pending && (timer_q == '0 || !owner_pending);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            owner_q <= ARBIT_SEND;
            timer_q <= '0;
        end else if (switch_owner) begin
            owner_q <= (owner_q == ARBIT_SEND) ? ARBIT_RECEIVE : ARBIT_SEND;
            timer_q <= SLICE_CYCLES;
        end else if (timer_q != '0) begin
            timer_q <= timer_q - 4'd1;
        end
    end

    assign send_grant_o    = (owner_q == ARBIT_SEND);
    assign receive_grant_o = (owner_q == ARBIT_RECEIVE);

    ////////////////////
    // Memory port mux
    ////////////////////

    always_comb begin
        if (owner_q == ARBIT_RECEIVE) begin
            mem_req_o = receive_req_i;
            if (!receive_pending_i) begin
                mem_req_o.we = 4'h0;
            end
        end else begin
            mem_req_o    = send_req_i;
            mem_req_o.we = 4'h0;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot({send_grant_o, receive_grant_o}));

endmodule

// File: noc_receive.sv
module noc_receive
    import dma_noc_pkg::*;
    import dma_cfg_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  noc_in_t  noc_i,
    output logic     noc_credit_o,
    input  dma_cfg_t cfg_i,
    input  logic     grant_i,
    output logic     pending_o,
    output mem_req_t mem_req_o,
    output logic     receive_active_o,
    output logic     receive_available_o,
    output flit_t    flits_available_o
);

    typedef enum logic [3:0] {
        RX_HEADER = 4'b0001,
        RX_SIZE   = 4'b0010,
        RX_WAIT   = 4'b0100,
        RX_DATA   = 4'b1000
    } rx_state_t;

    rx_state_t   state_q;
    rx_state_t   state_d;
    addr_t       addr_q;
    logic [31:0] count_q;
    flit_t       payload_q;
    logic        accept;
    logic        take_cmd;

    // Payload flit written to memory this cycle
    assign accept   = (state_q == RX_DATA) && noc_i.rx && grant_i;
    assign take_cmd = (state_q == RX_WAIT) && cfg_i.start
                      && (cfg_i.operation == HERMES_OP_RECEIVE);

    ////////////////////
    // State machine
    ////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            RX_HEADER: if (noc_i.rx) state_d = RX_SIZE;
            RX_SIZE:   if (noc_i.rx) state_d = RX_WAIT;
            RX_WAIT:   if (take_cmd) state_d = RX_DATA;
            RX_DATA: begin
                // End of packet wins over end of command
                if (accept && payload_q == 32'd1) begin
                    state_d = RX_HEADER;
                end else if (accept && count_q == 32'd1) begin
                    state_d = RX_WAIT;
                end
            end
            default:   state_d = RX_HEADER;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= RX_HEADER;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////
    // Counters
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            payload_q <= '0;
        end else if (state_q == RX_SIZE && noc_i.rx) begin
            payload_q <= noc_i.data;
        end else if (accept) begin
            payload_q <= payload_q - 32'd1;
        end
    end

    // Destination pointer and words left in the command
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            addr_q  <= '0;
            count_q <= '0;
        end else if (take_cmd) begin
            addr_q  <= cfg_i.address;
            count_q <= cfg_i.size;
        end else if (accept) begin
            addr_q  <= addr_q + addr_t'(WORD_BYTES);
            count_q <= count_q - 32'd1;
        end
    end

    assign noc_credit_o = (state_q == RX_HEADER) || (state_q == RX_SIZE) || accept;

    always_comb begin
        mem_req_o.we    = (state_q == RX_DATA && noc_i.rx) ? 4'hF : 4'h0;
        mem_req_o.addr  = addr_q;
        mem_req_o.wdata = noc_i.data;
    end

    assign pending_o           = (state_q == RX_DATA);
    assign receive_active_o    = (state_q == RX_DATA);
    assign receive_available_o = (state_q == RX_WAIT);
    assign flits_available_o   = payload_q;

    // No flit taken while waiting for a command
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_q == RX_WAIT) |-> !noc_credit_o);

endmodule

// File: noc_send.sv
module noc_send
    import dma_noc_pkg::*;
    import dma_cfg_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  dma_cfg_t cfg_i,
    input  logic     grant_i,
    input  logic     noc_ack_i,
    input  flit_t    mem_rdata_i,
    output logic     noc_tx_o,
    output flit_t    noc_data_o,
    output logic     pending_o,
    output mem_req_t mem_req_o,
    output logic     send_active_o
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_PRELOAD,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    // Read position over both buffers
    typedef struct packed {
        addr_t       addr;
        logic [31:0] size;
        addr_t       addr_2;
        logic [31:0] size_2;
    } send_ptr_t;

    tx_state_t state_q;
    tx_state_t state_d;
    send_ptr_t ptr_q;
    send_ptr_t ptr_next;
    send_ptr_t bk_q;
    logic      take_cmd;
    logic      last_word;
    logic      issue;
    logic      rollback;

    assign take_cmd = (state_q == TX_IDLE) && cfg_i.start
                      && (cfg_i.operation == HERMES_OP_SEND)
                      && (cfg_i.size != '0 || cfg_i.size_2 != '0);

    assign last_word = (ptr_q.size == 32'd1 && ptr_q.size_2 == '0)
                       || (ptr_q.size == '0 && ptr_q.size_2 == 32'd1);

    // Step to the next word, buffer 1 drains first
    always_comb begin
        ptr_next = ptr_q;
        if (ptr_q.size != '0) begin
            ptr_next.addr = ptr_q.addr + addr_t'(WORD_BYTES);
            ptr_next.size = ptr_q.size - 32'd1;
        end else begin
            ptr_next.addr_2 = ptr_q.addr_2 + addr_t'(WORD_BYTES);
            ptr_next.size_2 = ptr_q.size_2 - 32'd1;
        end
    end

    ////////////////////
    // State machine
    ////////////////////

    always_comb begin
        state_d  = state_q;
        issue    = 1'b0;
        rollback = 1'b0;
        case (state_q)
            TX_IDLE: if (take_cmd) state_d = TX_PRELOAD;
            TX_PRELOAD: begin
                if (grant_i && noc_ack_i) begin
                    issue   = 1'b1;
                    state_d = last_word ? TX_STOP : TX_DATA;
                end
            end
            TX_DATA: begin
                if (!noc_ack_i) begin
                    rollback = 1'b1;
                    state_d  = TX_PRELOAD;
                end else if (grant_i) begin
                    issue   = 1'b1;
                    state_d = last_word ? TX_STOP : TX_DATA;
                end else begin
                    // Flit delivered but nothing read behind it
                    state_d = TX_PRELOAD;
                end
            end
            TX_STOP: begin
                if (!noc_ack_i) begin
                    rollback = 1'b1;
                    state_d  = TX_PRELOAD;
                end else begin
                    state_d = TX_IDLE;
                end
            end
            default: state_d = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= TX_IDLE;
            ptr_q   <= '0;
        end else begin
            state_q <= state_d;
            if (take_cmd) begin
                ptr_q <= {cfg_i.address, cfg_i.size, cfg_i.address_2, cfg_i.size_2};
            end else if (rollback) begin
                ptr_q <= bk_q;
            end else if (issue) begin
                ptr_q <= ptr_next;
            end
        end
    end

    // Position of the word now on noc_data_o
    always_ff @(posedge clk_i) begin
        if (issue) begin
            bk_q <= ptr_q;
        end
    end

    always_comb begin
        mem_req_o.we    = 4'h0;
        mem_req_o.addr  = (ptr_q.size != '0) ? ptr_q.addr : ptr_q.addr_2;
        mem_req_o.wdata = '0;
    end

    assign noc_tx_o      = (state_q == TX_DATA) || (state_q == TX_STOP);
    assign noc_data_o    = mem_rdata_i;
    assign pending_o     = (state_q == TX_PRELOAD) || (state_q == TX_DATA);
    assign send_active_o = (state_q != TX_IDLE);

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_q == TX_IDLE) |-> !noc_tx_o);

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module hermes_dma_tb -f hermes_dma.f

result=$(./obj_dir/Vhermes_dma_tb || true)
echo "$result"

if echo "$result" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1
